/* include/laser_config.svh */
// ================================================
// Laser 500 glue core configuration
// Register map, RAM geometry, erase range and
// pacing, DAC width
// ================================================
`ifndef LASER_CONFIG_SVH
`define LASER_CONFIG_SVH

`define LASER_RAM_AW            25      // RAM byte address bits
`define LASER_PAGE_BITS         14      // 16K pages

// Erase range, pages 3 to 7
`define LASER_ERASE_FIRST_PAGE  3
`define LASER_ERASE_END_PAGE    8       // One past the last page
`define LASER_ERASE_DIV         4       // F14M cycles per eraser write

`define LASER_DAC_BITS          16

// APB offsets
`define LASER_REG_CTRL          4'h0
`define LASER_REG_DL_ADDR       4'h4
`define LASER_REG_DL_DATA       4'h8
`define LASER_REG_STATUS        4'hC

`endif

/* logic/laser_pkg.sv */
// ================================================
// Laser 500 glue core types
// Bus widths, memory request struct and FSM enums
// ================================================
`default_nettype none

`include "laser_config.svh"

package laser_pkg;

	typedef logic [`LASER_RAM_AW-1:0]   ram_addr_t;    // RAM byte address
	typedef logic [7:0]                 ram_data_t;
	typedef logic [3:0]                 apb_addr_t;    // APB offset
	typedef logic [31:0]                apb_data_t;
	typedef logic [`LASER_DAC_BITS-1:0] dac_sample_t;

	// One request on the shared RAM port
	typedef struct packed {
		ram_addr_t addr;
		ram_data_t data;
		logic      wr;     // Write strobe
		logic      rd;     // Read strobe
	} mem_req_t;

	// Boot and reset sequence
	typedef enum logic [1:0] {
		BOOT_IDLE,
		BOOT_LOADING,     // Host download running
		BOOT_ERASING,     // RAM pages being cleared
		BOOT_RUN
	} boot_state_t;

	// Owner of the RAM port, highest priority first
	typedef enum logic [1:0] {
		SRC_DOWNLOAD,
		SRC_ERASE,
		SRC_VIDEO
	} mem_src_t;

endpackage

`default_nettype wire

/* logic/sys_control.sv */
// ================================================
// Host control block
// APB registers, download address counter and the
// boot / reset sequencer for CPU reset and blank
// ================================================
`timescale 1ns/100ps
`default_nettype none

`include "laser_config.svh"

module sys_control (
	input  wire                  F14M,
	input  wire                  rst,
	input  wire                  psel,
	input  wire                  penable,
	input  wire                  pwrite,
	input  laser_pkg::apb_addr_t paddr,
	input  laser_pkg::apb_data_t pwdata,
	output laser_pkg::apb_data_t prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  wire                  erasing,      // Eraser busy
	input  wire                  reset_key,
	output laser_pkg::mem_req_t  dl_req,
	output logic                 erase_start,  // One-cycle trigger
	output logic                 cpu_reset,
	output logic                 blank,
	output logic                 alt_font
);
	import laser_pkg::*;

	boot_state_t state;
	ram_addr_t   dl_addr;        // Next download address
	logic        power_on;       // Hold CPU in reset
	logic        dl_active;
	logic        boot_done;      // Sticky
	logic        apb_wr;
	logic        reg_ok;
	logic        in_load;
	logic        in_erase;

	assign apb_wr   = psel & penable & pwrite;   // Access phase write
	assign in_load  = (state == BOOT_LOADING);
	assign in_erase = (state == BOOT_ERASING);

	// Only the four word offsets are mapped
	assign reg_ok  = (paddr == `LASER_REG_CTRL)    || (paddr == `LASER_REG_DL_ADDR) ||
	                 (paddr == `LASER_REG_DL_DATA) || (paddr == `LASER_REG_STATUS);
	assign pready  = 1'b1;                         // No wait states
	assign pslverr = psel & penable & ~reg_ok;

	always_comb begin
		case (paddr)
			`LASER_REG_CTRL:    prdata = {27'd0, boot_done, dl_active, 1'b0, alt_font, power_on};
			`LASER_REG_DL_ADDR: prdata = {{(32-`LASER_RAM_AW){1'b0}}, dl_addr};
			`LASER_REG_STATUS:  prdata = {29'd0, boot_done, in_load, erasing};
			default:            prdata = '0;      // DL_DATA is write only
		endcase
	end

	// Download write goes out in the access phase itself
	assign dl_req.addr = dl_addr;
	assign dl_req.data = pwdata[7:0];
	assign dl_req.wr   = apb_wr && (paddr == `LASER_REG_DL_DATA);
	assign dl_req.rd   = 1'b0;

	// Reset request bit, ignored while an erase runs
	assign erase_start = apb_wr && (paddr == `LASER_REG_CTRL) && pwdata[2] && !in_erase;

	always_ff @(posedge F14M) begin
		if (rst) begin
			power_on  <= 1'b0;
			alt_font  <= 1'b0;
			dl_active <= 1'b0;
			boot_done <= 1'b0;
			dl_addr   <= '0;
		end else if (apb_wr) begin
			if (paddr == `LASER_REG_CTRL) begin
				power_on  <= pwdata[0];
				alt_font  <= pwdata[1];
				dl_active <= pwdata[3];
				boot_done <= boot_done | pwdata[4];    // Never clears
			end
			if (paddr == `LASER_REG_DL_ADDR)
				dl_addr <= pwdata[`LASER_RAM_AW-1:0];
			if (paddr == `LASER_REG_DL_DATA)
				dl_addr <= dl_addr + 1'b1;             // Auto increment
		end
	end

	// Boot sequencer
	always_ff @(posedge F14M) begin
		if (rst) begin
			state <= BOOT_IDLE;
		end else if (erase_start) begin
			state <= BOOT_ERASING;
		end else begin
			case (state)
				BOOT_IDLE: begin
					if (dl_active)
						state <= BOOT_LOADING;
					else if (boot_done)
						state <= BOOT_RUN;
				end
				BOOT_LOADING: begin
					if (!dl_active)
						state <= boot_done ? BOOT_RUN : BOOT_IDLE;
				end
				BOOT_ERASING: begin
					if (!erasing)                      // Eraser finished
						state <= boot_done ? BOOT_RUN : BOOT_IDLE;
				end
				default: begin
					if (dl_active)
						state <= BOOT_LOADING;         // Reload from run
				end
			endcase
		end
	end

	assign cpu_reset = ~boot_done | in_load | in_erase | reset_key | power_on;
	assign blank     = ~boot_done | in_load | in_erase;

endmodule

`default_nettype wire

/* logic/ram_eraser.sv */
// ================================================
// RAM eraser
// Writes zero bytes over pages 3 to 7, one write
// every few F14M cycles, pausing under hold
// ================================================
`timescale 1ns/100ps
`default_nettype none

`include "laser_config.svh"

module ram_eraser (
	input  wire                 F14M,
	input  wire                 rst,
	input  wire                 start,     // Erase trigger
	input  wire                 hold,      // Port taken by download
	output laser_pkg::mem_req_t er_req,
	output logic                er_busy
);
	import laser_pkg::*;

	localparam int        DIV_W      = $clog2(`LASER_ERASE_DIV);
	localparam ram_addr_t FIRST_ADDR = ram_addr_t'(`LASER_ERASE_FIRST_PAGE << `LASER_PAGE_BITS);
	localparam ram_addr_t LAST_ADDR  = ram_addr_t'((`LASER_ERASE_END_PAGE << `LASER_PAGE_BITS) - 1);

	ram_addr_t        er_addr;
	logic [DIV_W-1:0] div_cnt;    // Pacing divider
	logic             wr_now;

	// Last divider slot, held back while a download writes
	assign wr_now = er_busy && (div_cnt == DIV_W'(`LASER_ERASE_DIV - 1)) && !hold;

	always_ff @(posedge F14M) begin
		if (rst) begin
			er_busy <= 1'b0;
			div_cnt <= '0;
			er_addr <= FIRST_ADDR;
		end else if (start) begin
			er_busy <= 1'b1;
			div_cnt <= '0;
			er_addr <= FIRST_ADDR;
		end else if (er_busy) begin
			if (wr_now) begin
				div_cnt <= '0;
				er_addr <= er_addr + 1'b1;
				if (er_addr == LAST_ADDR)
					er_busy <= 1'b0;                     // Drops after last write
			end else if (div_cnt != DIV_W'(`LASER_ERASE_DIV - 1)) begin
				div_cnt <= div_cnt + 1'b1;               // Waits at top under hold
			end
		end
	end

	assign er_req.addr = er_addr;
	assign er_req.data = '0;
	assign er_req.wr   = wr_now;
	assign er_req.rd   = 1'b0;

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
// ================================================
// RAM port arbiter
// Fixed priority download > eraser > video, with
// the chosen request registered for one cycle
// ================================================
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
	input  wire                 F14M,
	input  wire                 rst,
	input  laser_pkg::mem_req_t dl_req,
	input  laser_pkg::mem_req_t er_req,
	input  laser_pkg::mem_req_t vid_req,
	output laser_pkg::mem_req_t mem_out,
	output logic                vid_stall   // Video lost the port
);
	import laser_pkg::*;

	mem_src_t src;
	mem_req_t sel_req;

	always_comb begin
		if (dl_req.wr)
			src = SRC_DOWNLOAD;      // Download always wins
		else if (er_req.wr)
			src = SRC_ERASE;
		else
			src = SRC_VIDEO;
	end

	always_comb begin
		case (src)
			SRC_DOWNLOAD: sel_req = dl_req;
			SRC_ERASE:    sel_req = er_req;
			default:      sel_req = vid_req;
		endcase
	end

	always_ff @(posedge F14M) begin
		if (rst) begin
			mem_out   <= '0;
			vid_stall <= 1'b0;
		end else begin
			mem_out   <= sel_req;      // One cycle latency
			vid_stall <= (vid_req.rd | vid_req.wr) && (src != SRC_VIDEO);
		end
	end

endmodule

`default_nettype wire

/* logic/audio_dac.sv */
// ================================================
// Audio path
// Cassette latch, one-bit mix of buzzer and tape,
// first-order sigma-delta DAC on both pins
// ================================================
`timescale 1ns/100ps
`default_nettype none

`include "laser_config.svh"

module audio_dac (
	input  wire  F14M,
	input  wire  rst,
	input  wire  uart_rx,     // Tape input, inverted
	input  wire  buzzer,      // Keyboard speaker
	input  wire  cas_out,     // Tape save line
	output logic audio_l,
	output logic audio_r
);
	import laser_pkg::*;

	logic                     cas_in_q;
	logic                     mix;
	dac_sample_t              sample;
	logic [`LASER_DAC_BITS:0] acc;    // Carry is the audio bit

	assign mix    = buzzer ^ cas_in_q ^ ~cas_out;
	assign sample = {mix, {(`LASER_DAC_BITS-1){1'b0}}};   // Mix bit on MSB

	always_ff @(posedge F14M) begin
		if (rst) begin
			cas_in_q <= 1'b0;
			acc      <= '0;
			audio_l  <= 1'b0;
			audio_r  <= 1'b0;
		end else begin
			cas_in_q <= ~uart_rx;
			// Keep the residue, add the new sample
			acc      <= {1'b0, acc[`LASER_DAC_BITS-1:0]} + {1'b0, sample};
			audio_l  <= acc[`LASER_DAC_BITS];
			audio_r  <= acc[`LASER_DAC_BITS];   // Same signal both sides
		end
	end

endmodule

`default_nettype wire

/* logic/laser_sys_core.sv */
// ================================================
// Laser 500 system core
// Host control, RAM eraser, memory arbiter and
// audio DAC on the F14M clock
// ================================================
`timescale 1ns/100ps
`default_nettype none

module laser_sys_core (
	input  wire                  F14M,
	input  wire                  rst,
	// APB slave
	input  wire                  psel,
	input  wire                  penable,
	input  wire                  pwrite,
	input  laser_pkg::apb_addr_t paddr,
	input  laser_pkg::apb_data_t pwdata,
	output laser_pkg::apb_data_t prdata,
	output logic                 pready,
	output logic                 pslverr,
	// Board side
	input  wire                  reset_key,   // From keyboard
	input  wire                  uart_rx,     // Cassette in
	input  wire                  buzzer,
	input  wire                  cas_out,
	input  laser_pkg::mem_req_t  vid_req,     // From video chip
	output logic                 cpu_reset,
	output logic                 blank,
	output logic                 alt_font,
	output logic                 audio_l,
	output logic                 audio_r,
	output laser_pkg::mem_req_t  mem_out,     // Shared RAM port
	output logic                 vid_stall
);
	import laser_pkg::*;

	mem_req_t dl_req;      // Host download write
	mem_req_t er_req;      // Eraser write
	logic     er_busy;
	logic     erase_start;

	sys_control u_ctrl (
		.F14M(F14M), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.erasing(er_busy), .reset_key(reset_key),
		.dl_req(dl_req), .erase_start(erase_start),
		.cpu_reset(cpu_reset), .blank(blank), .alt_font(alt_font)
	);

	// Eraser waits while a download write owns the port
	ram_eraser u_eraser (
		.F14M(F14M), .rst(rst),
		.start(erase_start), .hold(dl_req.wr),
		.er_req(er_req), .er_busy(er_busy)
	);

	mem_arbiter u_arb (
		.F14M(F14M), .rst(rst),
		.dl_req(dl_req), .er_req(er_req), .vid_req(vid_req),
		.mem_out(mem_out), .vid_stall(vid_stall)
	);

	audio_dac u_audio (
		.F14M(F14M), .rst(rst),
		.uart_rx(uart_rx), .buzzer(buzzer), .cas_out(cas_out),
		.audio_l(audio_l), .audio_r(audio_r)
	);

endmodule

`default_nettype wire

/* tests/laser_sys_core_asserts.sv */
// ==================================================
// Laser 500 core assertions
// Arbiter priority and boot/reset relations
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module laser_sys_core_asserts (
	input wire                    F14M,
	input wire                    rst,
	input laser_pkg::mem_req_t    dl_req,      // Download request
	input laser_pkg::mem_req_t    mem_out,     // Registered RAM port
	input laser_pkg::boot_state_t state,
	input wire                    blank,
	input wire                    cpu_reset,
	input wire                    er_busy
);
	import laser_pkg::*;

	// Download write lands on the port next cycle, eraser kept off
	dl_over_erase: assert property (@(posedge F14M) disable iff (rst)
		dl_req.wr |=> (mem_out == $past(dl_req)))
		else $error("download write did not reach the RAM port");

	// Running eraser keeps video blanked and CPU in reset
	erase_blanks: assert property (@(posedge F14M) disable iff (rst)
		er_busy |-> (blank && cpu_reset))
		else $error("blank or cpu_reset low while the eraser runs");

	erase_in_state: assert property (@(posedge F14M) disable iff (rst)
		$rose(er_busy) |-> (state == BOOT_ERASING))
		else $error("eraser started outside the erasing state");

endmodule

// Control side inputs tied inactive on the arbiter
bind mem_arbiter laser_sys_core_asserts u_arb_asserts (
	.F14M(F14M), .rst(rst), .dl_req(dl_req), .mem_out(mem_out),
	.state(laser_pkg::BOOT_ERASING), .blank(1'b0), .cpu_reset(1'b0), .er_busy(1'b0)
);

// Arbiter side inputs tied inactive on the control block
bind sys_control laser_sys_core_asserts u_ctrl_asserts (
	.F14M(F14M), .rst(rst), .dl_req('0), .mem_out('0),
	.state(state), .blank(blank), .cpu_reset(cpu_reset), .er_busy(erasing)
);

`default_nettype wire

/* tests/tb_laser_sys_core.sv */
// ==================================================
// Laser 500 system core testbench
// Golden-file APB stimulus with RAM port, erase,
// priority and audio checks under a watchdog
// ==================================================
`timescale 1ns/100ps
`default_nettype none

`include "laser_config.svh"

module tb_laser_sys_core;
	import laser_pkg::*;

	localparam int     CLK_HALF   = 50;      // 100 ns period
	localparam int     DRIVE_DLY  = 10;      // Inputs change here after the edge
	localparam int     SAMPLE_DLY = 40;      // APB read data taken here
	localparam int     AUDIO_WIN  = 64;
	localparam longint ERASE_CYC  = longint'((`LASER_ERASE_END_PAGE - `LASER_ERASE_FIRST_PAGE)
	                                << `LASER_PAGE_BITS) * `LASER_ERASE_DIV;
	localparam longint OTHER_CYC  = 4000;    // Everything but the erase, with margin
	localparam longint TIMEOUT_NS = (ERASE_CYC * 3 / 2 + OTHER_CYC) * 2 * CLK_HALF;

	localparam int OP_RESET = 0;
	localparam int OP_WRITE = 1;
	localparam int OP_READ  = 2;
	localparam int OP_MEM   = 3;             // expect-mem, video vs download
	localparam int OP_AUDIO = 4;
	localparam int OP_ERASE = 5;
	localparam int OP_BAD   = 6;

	logic      F14M;
	logic      rst;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      reset_key;
	logic      uart_rx;
	logic      buzzer;
	logic      cas_out;
	mem_req_t  vid_req;
	logic      cpu_reset;
	logic      blank;
	logic      alt_font;
	logic      audio_l;
	logic      audio_r;
	mem_req_t  mem_out;
	logic      vid_stall;

	int         err_count;
	int         test_num;
	int         fail_tests;
	logic       er_watch;              // Eraser monitor armed
	int         er_count;
	int         er_gaps;               // Non-consecutive or non-zero writes
	ram_addr_t  er_first;
	ram_addr_t  er_last;

	laser_sys_core u_laser_sys_core (
		.F14M(F14M), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.reset_key(reset_key), .uart_rx(uart_rx), .buzzer(buzzer), .cas_out(cas_out),
		.vid_req(vid_req),
		.cpu_reset(cpu_reset), .blank(blank), .alt_font(alt_font),
		.audio_l(audio_l), .audio_r(audio_r),
		.mem_out(mem_out), .vid_stall(vid_stall)
	);

	always #(CLK_HALF) F14M = ~F14M;

	task automatic next_cycle();
		@(posedge F14M);
		#(DRIVE_DLY);                      // Back in the drive slot
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
	                         input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_cond(input bit ok, input string what);
		assert (ok) else begin
			$display("Check failed: %s", what);
			err_count++;
		end
	endtask

	// Setup then access phase, no wait states
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		next_cycle();
		penable = 1'b1;
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		next_cycle();
		penable = 1'b1;
		#(SAMPLE_DLY - DRIVE_DLY);
		data = prdata;                     // Mid access phase
		err  = pslverr;
		check_val("pready", pready, 1);    // No wait states
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Eraser writes on the RAM port, taken at the falling edge
	always @(negedge F14M) begin
		if (er_watch && mem_out.wr) begin
			if (er_count != 0 && mem_out.addr != er_last + 1'b1)
				er_gaps++;
			if (er_count == 0)
				er_first = mem_out.addr;
			if (mem_out.data != '0)
				er_gaps++;                 // Erased bytes must be zero
			er_last = mem_out.addr;
			er_count++;
		end
	end

	task automatic do_write(input apb_data_t a, input apb_data_t d, input apb_data_t e);
		apb_write(apb_addr_t'(a), d);
		if (a == `LASER_REG_DL_DATA) begin
			check_val("mem_out.wr", mem_out.wr, 1);        // One cycle after access
			check_val("mem_out.addr", mem_out.addr, e);
			check_val("mem_out.data", mem_out.data, d[7:0]);
		end else if (a == `LASER_REG_CTRL) begin
			next_cycle();                                  // Boot FSM settles
			next_cycle();
			check_val("blank", blank, e[1]);
			check_val("cpu_reset", cpu_reset, e[0]);
			check_val("alt_font", alt_font, d[1]);         // CTRL bit 1
		end
	endtask

	task automatic do_read(input apb_data_t a, input apb_data_t d, input apb_data_t e);
		apb_data_t rd;
		logic      err;
		apb_read(apb_addr_t'(a), rd, err);
		check_val("prdata", rd, e);
		check_val("pslverr", err, d[0]);
	endtask

	// Video read held while a download write takes the port
	task automatic check_priority(input apb_data_t a, input apb_data_t d, input apb_data_t e);
		vid_req.addr = ram_addr_t'(a);
		vid_req.data = '0;
		vid_req.wr   = 1'b0;
		vid_req.rd   = 1'b1;
		next_cycle();
		check_val("mem_out.rd", mem_out.rd, 1);            // Video alone owns it
		check_val("mem_out.addr", mem_out.addr, a);
		apb_write(`LASER_REG_DL_DATA, d);
		check_val("mem_out.wr", mem_out.wr, 1);
		check_val("mem_out.rd", mem_out.rd, 0);
		check_val("mem_out.addr", mem_out.addr, e);
		check_val("mem_out.data", mem_out.data, d[7:0]);
		check_val("vid_stall", vid_stall, 1);
		next_cycle();
		check_val("mem_out.rd", mem_out.rd, 1);            // Video back on the port
		check_val("vid_stall", vid_stall, 0);
		vid_req = '0;
	endtask

	task automatic run_erase(input apb_data_t first, input apb_data_t ctrl, input apb_data_t total);
		apb_data_t st;
		logic      err;
		er_count = 0;
		er_gaps  = 0;
		er_watch = 1'b1;
		apb_write(`LASER_REG_CTRL, ctrl);
		check_val("blank", blank, 1);
		check_val("cpu_reset", cpu_reset, 1);
		st = 32'h1;
		while (st[0]) begin
			apb_read(`LASER_REG_STATUS, st, err);          // Poll erasing bit
		end
		next_cycle();
		er_watch = 1'b0;
		check_val("erase write count", er_count, total);
		check_val("first erase address", er_first, first);
		check_val("last erase address", er_last, first + total - 1);
		check_val("erase sequence breaks", er_gaps, 0);
	endtask

	// addr bits are {uart_rx, buzzer, cas_out}
	task automatic check_audio(input apb_data_t a, input apb_data_t d, input apb_data_t e);
		int ones;
		int mism;
		uart_rx = a[2];
		buzzer  = a[1];
		cas_out = a[0];
		repeat (d) next_cycle();
		ones = 0;
		mism = 0;
		repeat (AUDIO_WIN) begin
			next_cycle();
			if (audio_l)
				ones++;
			if (audio_r !== audio_l)
				mism++;
		end
		check_val("audio_l ones", ones, e);
		check_val("audio_r mismatches", mism, 0);
	endtask

	function automatic int decode_op(input logic [127:0] s);
		if (s == "write")      return OP_WRITE;
		if (s == "read")       return OP_READ;
		if (s == "expect-mem") return OP_MEM;
		if (s == "audio")      return OP_AUDIO;
		if (s == "erase")      return OP_ERASE;
		return OP_BAD;
	endfunction

	function automatic string op_name(input int code);
		case (code)
			OP_RESET: return "reset";
			OP_WRITE: return "write";
			OP_READ:  return "read";
			OP_MEM:   return "expect-mem";
			OP_AUDIO: return "audio";
			OP_ERASE: return "erase";
			default:  return "unknown";
		endcase
	endfunction

	task automatic report_test(input int code, input int errs_before);
		test_num++;
		if (err_count != errs_before)
			fail_tests++;
		$display("test %0d %s: %s", test_num, op_name(code),
		         (err_count == errs_before) ? "ok" : "fail");
	endtask

	initial begin
		int              fd;
		int              n;
		int              code;
		int              errs_before;
		logic            eof_hit;
		logic [127:0]    op_s;
		logic [8*128-1:0] line_s;
		apb_data_t       g_addr;
		apb_data_t       g_data;
		apb_data_t       g_exp;
		F14M      = 1'b0;
		rst       = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		reset_key = 1'b0;
		uart_rx   = 1'b0;
		buzzer    = 1'b0;
		cas_out   = 1'b0;
		vid_req   = '0;
		er_watch  = 1'b0;
		er_count  = 0;
		er_gaps   = 0;
		err_count = 0;
		test_num  = 0;
		fail_tests = 0;
		eof_hit   = 1'b0;
		repeat (10) @(posedge F14M);
		#(DRIVE_DLY);
		errs_before = err_count;
		check_val("cpu_reset", cpu_reset, 1);              // boot_done clear
		check_val("blank", blank, 1);
		check_val("mem_out.wr", mem_out.wr, 0);
		check_val("mem_out.rd", mem_out.rd, 0);
		check_val("vid_stall", vid_stall, 0);
		check_val("audio_l", audio_l, 0);
		check_val("audio_r", audio_r, 0);
		report_test(OP_RESET, errs_before);
		rst = 1'b0;
		fd = $fopen("tests/laser_golden.txt", "r");
		check_cond(fd != 0, "golden file tests/laser_golden.txt could not be opened");
		while (fd != 0 && !eof_hit) begin
			n = $fscanf(fd, "%s", op_s);
			if (n != 1) begin
				eof_hit = 1'b1;                            // End of file
			end else if (op_s == "#") begin
				n = $fgets(line_s, fd);                    // Skip comment text
			end else begin
				n = $fscanf(fd, "%h %h %h", g_addr, g_data, g_exp);
				code = decode_op(op_s);
				errs_before = err_count;
				check_cond(n == 3 && code != OP_BAD, "golden line is malformed or unknown");
				if (n == 3) begin
					case (code)
						OP_WRITE: do_write(g_addr, g_data, g_exp);
						OP_READ:  do_read(g_addr, g_data, g_exp);
						OP_MEM:   check_priority(g_addr, g_data, g_exp);
						OP_AUDIO: check_audio(g_addr, g_data, g_exp);
						OP_ERASE: run_erase(g_addr, g_data, g_exp);
						default:  ;
					endcase
				end
				report_test(code, errs_before);
			end
		end
		if (fd != 0)
			$fclose(fd);
		check_cond(test_num > 1, "golden file held no tests");
		$display("tests run: %0d, tests failed: %0d, errors: %0d",
		         test_num, fail_tests, err_count);
		if (err_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog, erase length with half again as margin
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/laser_golden.txt */
# op addr data expected (hex); write DL_DATA: expected = RAM addr, CTRL: expected = {blank,cpu_reset}
# read: data = pslverr; expect-mem: addr = video addr; erase: data = CTRL, expected = write count
write 0 8 3
write 4 100 0
write 8 a5 100
write 8 3c 101
write 8 e7 102
read c 0 2
read 4 0 103
write 0 12 0
write 0 13 1
write 0 12 0
read 1 1 0
read 0 0 12
expect-mem 2345 5a 103
read 4 0 104
erase c000 16 14000
read c 0 4
read 0 0 12
audio 1 10 20
audio 5 14 0

/* flist.f */
+incdir+include
logic/laser_pkg.sv
logic/sys_control.sv
logic/ram_eraser.sv
logic/mem_arbiter.sv
logic/audio_dac.sv
logic/laser_sys_core.sv
tests/laser_sys_core_asserts.sv
tests/tb_laser_sys_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Laser 500 core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_laser_sys_core -o tb_laser_sys_core

sim_out=$(./obj_dir/tb_laser_sys_core || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
